// ==== source/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

    // Datapath width
    localparam int xlen = 32;

    // --------------------
    // Opcodes and function fields

    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111
    } opcodeE;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;  // SRA shares it, told apart by funct7
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;
    localparam logic [2:0] f3Blt    = 3'b100;
    localparam logic [2:0] f3Bge    = 3'b101;
    localparam logic [2:0] f3Bltu   = 3'b110;
    localparam logic [2:0] f3Bgeu   = 3'b111;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000;  // SUB and SRA

    // --------------------
    // ALU encodings

    typedef enum logic [1:0] {
        aluOpAdd    = 2'b00,  // Load and store address
        aluOpBranch = 2'b01,
        aluOpReg    = 2'b10,
        aluOpImm    = 2'b11
    } aluOpE;

    typedef enum logic [3:0] {
        aluNone,
        aluAdd,
        aluSub,
        aluSubUnsigned,
        aluAnd,
        aluOr,
        aluXor,
        aluShiftL,
        aluShiftR,
        aluShiftRArith,
        aluLessSigned,
        aluLessUnsigned
    } aluCtrlE;

    // --------------------
    // Instruction word views

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeE     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeE      opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcodeE     opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcodeE     opcode;
    } bTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
    } instrU;

    // Per-instruction control
    typedef struct packed {
        logic  regWrite;
        logic  aluSrc;    // Immediate as second operand
        aluOpE aluOp;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  branch;
        logic  jump;
    } ctrlT;

    // ADDI x0, x0, 0
    localparam logic [31:0] nopWord = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== source/instrFetch.sv ====
`default_nettype none

module instrFetch #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       branch,
    input  wire logic                       branchTaken,
    input  wire logic                       jump,
    input  wire logic [rvCorePkg::xlen-1:0] imm32,
    output logic      [rvCorePkg::xlen-1:0] pc,
    output logic      [rvCorePkg::xlen-1:0] pcPlus4
);

    logic [rvCorePkg::xlen-1:0] target;
    logic [rvCorePkg::xlen-1:0] pcNext;
    logic                       redirect;

    // --------------------
    // Next PC

    assign pcPlus4  = pc + 32'd4;
    assign target   = pc + imm32;  // PC-relative for both B and J
    assign redirect = (branch && branchTaken) || jump;
    assign pcNext   = redirect ? target : pcPlus4;

    // --------------------
    // PC register

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== source/ctrlDecoder.sv ====
`default_nettype none

module ctrlDecoder (
    input  wire rvCorePkg::instrU             instr,
    output rvCorePkg::ctrlT                   ctrl,
    output logic [rvCorePkg::xlen-1:0]        imm32
);

    rvCorePkg::opcodeE opcode;

    assign opcode = instr.rType.opcode;

    // --------------------
    // Control table

    always_comb begin
        ctrl = '0;  // Unknown opcodes stay inactive
        case (opcode)
            rvCorePkg::opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = rvCorePkg::aluOpReg;
            end
            rvCorePkg::opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = rvCorePkg::aluOpImm;
            end
            rvCorePkg::opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = rvCorePkg::aluOpAdd;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            rvCorePkg::opStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = rvCorePkg::aluOpAdd;
                ctrl.memWrite = 1'b1;
            end
            rvCorePkg::opBranch: begin
                ctrl.aluOp    = rvCorePkg::aluOpBranch;  // Compares rs1 with rs2
                ctrl.branch   = 1'b1;
            end
            rvCorePkg::opJal: begin
                ctrl.regWrite = 1'b1;  // Link into rd
                ctrl.jump     = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // --------------------
    // Immediate generation

    always_comb begin
        case (opcode)
            rvCorePkg::opImm,
            rvCorePkg::opLoad: begin
                imm32 = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            end
            rvCorePkg::opStore: begin
                imm32 = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
            end
            rvCorePkg::opBranch: begin
                // Offset bits scattered across the word, bit 0 implied
                imm32 = {{19{instr.bType.imm12}},
                         instr.bType.imm12,
                         instr.bType.imm11,
                         instr.bType.imm10to5,
                         instr.bType.imm4to1,
                         1'b0};
            end
            rvCorePkg::opJal: begin
                // J offset picked from the R fields
                // imm[19:12] sits where rs1 and funct3 are
                imm32 = {{11{instr.rType.funct7[6]}},
                         instr.rType.funct7[6],
                         instr.rType.rs1,
                         instr.rType.funct3,
                         instr.rType.rs2[0],
                         instr.rType.funct7[5:0],
                         instr.rType.rs2[4:1],
                         1'b0};
            end
            default: begin
                imm32 = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`default_nettype none

module regFile (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic [4:0]                 rs1,
    input  wire logic [4:0]                 rs2,
    input  wire logic [4:0]                 rd,
    input  wire logic [rvCorePkg::xlen-1:0] writeData,
    input  wire logic                       regWrite,
    output logic      [rvCorePkg::xlen-1:0] readData1,
    output logic      [rvCorePkg::xlen-1:0] readData2
);

    logic [rvCorePkg::xlen-1:0] regs [32];

    // --------------------
    // Write port

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rd != 5'd0)) begin  // x0 never written
            regs[rd] <= writeData;
        end
    end

    // Combinational reads
    assign readData1 = regs[rs1];
    assign readData2 = regs[rs2];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`default_nettype none

module alu (
    input  wire logic [rvCorePkg::xlen-1:0] readData1,
    input  wire logic [rvCorePkg::xlen-1:0] readData2,
    input  wire logic [rvCorePkg::xlen-1:0] imm32,
    input  wire logic                       aluSrc,
    input  wire rvCorePkg::aluOpE           aluOp,
    input  wire logic [2:0]                 funct3,
    input  wire logic [6:0]                 funct7,
    output logic      [rvCorePkg::xlen-1:0] aluResult,
    output logic                            branchTaken
);

    rvCorePkg::aluCtrlE         aluCtrl;
    logic [rvCorePkg::xlen-1:0] operand1;
    logic [rvCorePkg::xlen-1:0] operand2;
    logic [rvCorePkg::xlen:0]   diffWide;      // Sign-extended difference
    logic [2*rvCorePkg::xlen-1:0] shiftWide;
    logic                       lessSigned;
    logic                       lessUnsigned;
    logic                       isZero;

    assign operand1 = readData1;
    assign operand2 = aluSrc ? imm32 : readData2;

    // --------------------
    // Operation select

    always_comb begin
        aluCtrl = rvCorePkg::aluNone;
        case (aluOp)
            rvCorePkg::aluOpAdd: aluCtrl = rvCorePkg::aluAdd;
            rvCorePkg::aluOpBranch: begin
                if (funct3 == rvCorePkg::f3Bltu || funct3 == rvCorePkg::f3Bgeu) begin
                    aluCtrl = rvCorePkg::aluSubUnsigned;
                end else begin
                    aluCtrl = rvCorePkg::aluSub;
                end
            end
            rvCorePkg::aluOpReg: begin
                case ({funct7, funct3})
                    {rvCorePkg::f7Base, rvCorePkg::f3AddSub}: aluCtrl = rvCorePkg::aluAdd;
                    {rvCorePkg::f7Alt,  rvCorePkg::f3AddSub}: aluCtrl = rvCorePkg::aluSub;
                    {rvCorePkg::f7Base, rvCorePkg::f3Xor}:    aluCtrl = rvCorePkg::aluXor;
                    {rvCorePkg::f7Base, rvCorePkg::f3Or}:     aluCtrl = rvCorePkg::aluOr;
                    {rvCorePkg::f7Base, rvCorePkg::f3And}:    aluCtrl = rvCorePkg::aluAnd;
                    {rvCorePkg::f7Base, rvCorePkg::f3Sll}:    aluCtrl = rvCorePkg::aluShiftL;
                    {rvCorePkg::f7Base, rvCorePkg::f3Srl}:    aluCtrl = rvCorePkg::aluShiftR;
                    {rvCorePkg::f7Alt,  rvCorePkg::f3Srl}:    aluCtrl = rvCorePkg::aluShiftRArith;
                    {rvCorePkg::f7Base, rvCorePkg::f3Slt}:    aluCtrl = rvCorePkg::aluLessSigned;
                    {rvCorePkg::f7Base, rvCorePkg::f3Sltu}:   aluCtrl = rvCorePkg::aluLessUnsigned;
                    default:                                  aluCtrl = rvCorePkg::aluNone;
                endcase
            end
            rvCorePkg::aluOpImm: begin
                case (funct3)
                    rvCorePkg::f3AddSub: aluCtrl = rvCorePkg::aluAdd;
                    rvCorePkg::f3Xor:    aluCtrl = rvCorePkg::aluXor;
                    rvCorePkg::f3Or:     aluCtrl = rvCorePkg::aluOr;
                    rvCorePkg::f3And:    aluCtrl = rvCorePkg::aluAnd;
                    rvCorePkg::f3Sll:    aluCtrl = rvCorePkg::aluShiftL;
                    rvCorePkg::f3Srl:    aluCtrl = funct7[5] ? rvCorePkg::aluShiftRArith
                                                             : rvCorePkg::aluShiftR;
                    rvCorePkg::f3Slt:    aluCtrl = rvCorePkg::aluLessSigned;
                    rvCorePkg::f3Sltu:   aluCtrl = rvCorePkg::aluLessUnsigned;
                    default:             aluCtrl = rvCorePkg::aluNone;
                endcase
            end
            default: aluCtrl = rvCorePkg::aluNone;
        endcase
    end

    // --------------------
    // Datapath

    assign diffWide     = {operand1[31], operand1} - {operand2[31], operand2};
    assign lessSigned   = diffWide[rvCorePkg::xlen];  // No overflow at 33 bits
    assign lessUnsigned = operand1 < operand2;
    assign shiftWide    = {{rvCorePkg::xlen{operand1[31]}}, operand1} >> operand2[4:0];

    always_comb begin
        case (aluCtrl)
            rvCorePkg::aluAdd:          aluResult = operand1 + operand2;
            rvCorePkg::aluSub,
            rvCorePkg::aluSubUnsigned:  aluResult = diffWide[rvCorePkg::xlen-1:0];
            rvCorePkg::aluAnd:          aluResult = operand1 & operand2;
            rvCorePkg::aluOr:           aluResult = operand1 | operand2;
            rvCorePkg::aluXor:          aluResult = operand1 ^ operand2;
            rvCorePkg::aluShiftL:       aluResult = operand1 << operand2[4:0];
            rvCorePkg::aluShiftR:       aluResult = operand1 >> operand2[4:0];
            rvCorePkg::aluShiftRArith:  aluResult = shiftWide[rvCorePkg::xlen-1:0];
            rvCorePkg::aluLessSigned:   aluResult = {31'b0, lessSigned};
            rvCorePkg::aluLessUnsigned: aluResult = {31'b0, lessUnsigned};
            default:                    aluResult = '0;
        endcase
    end

    // --------------------
    // Branch condition

    assign isZero = (diffWide[rvCorePkg::xlen-1:0] == '0);

    always_comb begin
        branchTaken = 1'b0;
        if (aluOp == rvCorePkg::aluOpBranch) begin
            case (funct3)
                rvCorePkg::f3Beq:  branchTaken = isZero;
                rvCorePkg::f3Bne:  branchTaken = !isZero;
                rvCorePkg::f3Blt:  branchTaken = lessSigned;
                rvCorePkg::f3Bge:  branchTaken = !lessSigned;
                rvCorePkg::f3Bltu: branchTaken = lessUnsigned;
                rvCorePkg::f3Bgeu: branchTaken = !lessUnsigned;
                default:           branchTaken = 1'b0;  // Reserved encodings
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/cpuTop.sv ====
`default_nettype none

module cpuTop #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    output logic      [rvCorePkg::xlen-1:0] instrAddr,
    input  wire logic [31:0]                instrData,
    output logic      [rvCorePkg::xlen-1:0] dataAddr,
    output logic      [rvCorePkg::xlen-1:0] dataWdata,
    output logic                            dataWe,
    input  wire logic [rvCorePkg::xlen-1:0] dataRdata
);

    rvCorePkg::instrU           instr;
    rvCorePkg::ctrlT            ctrl;
    logic [rvCorePkg::xlen-1:0] pc;
    logic [rvCorePkg::xlen-1:0] pcPlus4;
    logic [rvCorePkg::xlen-1:0] imm32;
    logic [rvCorePkg::xlen-1:0] readData1;
    logic [rvCorePkg::xlen-1:0] readData2;
    logic [rvCorePkg::xlen-1:0] aluResult;
    logic [rvCorePkg::xlen-1:0] writeData;
    logic                       branchTaken;

    assign instr     = instrData;
    assign instrAddr = pc;

    // --------------------
    // Blocks

    instrFetch #(
        .resetPc     (resetPc)
    ) u_instrFetch (
        .clk         (clk),
        .rstN        (rstN),
        .branch      (ctrl.branch),
        .branchTaken (branchTaken),
        .jump        (ctrl.jump),
        .imm32       (imm32),
        .pc          (pc),
        .pcPlus4     (pcPlus4)
    );

    ctrlDecoder u_ctrlDecoder (
        .instr (instr),
        .ctrl  (ctrl),
        .imm32 (imm32)
    );

    regFile u_regFile (
        .clk       (clk),
        .rstN      (rstN),
        .rs1       (instr.rType.rs1),
        .rs2       (instr.rType.rs2),
        .rd        (instr.rType.rd),
        .writeData (writeData),
        .regWrite  (ctrl.regWrite),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    alu u_alu (
        .readData1   (readData1),
        .readData2   (readData2),
        .imm32       (imm32),
        .aluSrc      (ctrl.aluSrc),
        .aluOp       (ctrl.aluOp),
        .funct3      (instr.rType.funct3),
        .funct7      (instr.rType.funct7),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    // --------------------
    // Write-back and data port

    assign writeData = ctrl.jump     ? pcPlus4    // JAL link
                     : ctrl.memToReg ? dataRdata
                     : aluResult;

    assign dataAddr  = aluResult;
    assign dataWdata = readData2;  // SW stores rs2
    assign dataWe    = ctrl.memWrite;

endmodule

`default_nettype wire

// ==== verification/cpuTop_chk.sv ====
`default_nettype none

module cpuTop_chk (
    input wire logic                       clk,
    input wire logic                       rstN,
    input wire logic [rvCorePkg::xlen-1:0] instrAddr,
    input wire logic                       dataWe,
    input wire rvCorePkg::ctrlT            ctrl,
    input wire logic [4:0]                 rs1,
    input wire logic [4:0]                 rs2,
    input wire logic [rvCorePkg::xlen-1:0] readData1,
    input wire logic [rvCorePkg::xlen-1:0] readData2
);

    int failCount = 0;  // Read by the testbench

    // --------------------
    // Core properties

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
        instrAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("instruction address %h is not word aligned", instrAddr);
        end

    storeNotLoad: assert property (@(posedge clk) disable iff (!rstN)
        !(dataWe && ctrl.memRead))
        else begin
            failCount++;
            $error("store strobe raised during a load");
        end

    // Reads of x0 must come back as zero on both ports
    x0Zero: assert property (@(posedge clk) disable iff (!rstN)
        (rs1 != 5'd0 || readData1 == '0) && (rs2 != 5'd0 || readData2 == '0))
        else begin
            failCount++;
            $error("register x0 read as nonzero");
        end

    quietInReset: assert property (@(posedge clk) !rstN |-> !dataWe)
        else begin
            failCount++;
            $error("store strobe high while in reset");
        end

endmodule

bind cpuTop cpuTop_chk u_cpuTopChk (
    .clk       (clk),
    .rstN      (rstN),
    .instrAddr (instrAddr),
    .dataWe    (dataWe),
    .ctrl      (ctrl),
    .rs1       (instr.rType.rs1),
    .rs2       (instr.rType.rs2),
    .readData1 (readData1),
    .readData2 (readData2)
);

`default_nettype wire

// ==== verification/cpuTopTb.sv ====
`default_nettype none

module cpuTopTb;

    localparam logic [31:0] resetPc    = 32'h0000_0000;
    localparam int          patternMax = 256;
    localparam int          dataWords  = 256;

    logic                       clk;
    logic                       rstN;
    rvCorePkg::instrU           instrData;
    logic [rvCorePkg::xlen-1:0] instrAddr;
    logic [rvCorePkg::xlen-1:0] dataAddr;
    logic [rvCorePkg::xlen-1:0] dataWdata;
    logic                       dataWe;
    logic [rvCorePkg::xlen-1:0] dataRdata;

    logic [31:0]                patterns [0:patternMax-1];
    logic [rvCorePkg::xlen-1:0] dataMem  [0:dataWords-1];

    int progLen    = 0;
    int storeCount = 0;
    int storesSeen = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    cpuTop #(
        .resetPc   (resetPc)
    ) u_cpuTop (
        .clk       (clk),
        .rstN      (rstN),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWe    (dataWe),
        .dataRdata (dataRdata)
    );

    assign dataRdata = dataMem[dataAddr[9:2]];  // Combinational read port

    // --------------------
    // Helpers

    task automatic abortRun();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    // Test group from the store area of the expected address
    function automatic string testName(input logic [rvCorePkg::xlen-1:0] addr);
        if (addr < 32'h140) return "r-type alu";
        if (addr < 32'h180) return "i-type alu";
        if (addr < 32'h1c0) return "slt compare";
        if (addr < 32'h200) return "branch";
        if (addr < 32'h240) return "load store";
        return "jal link";
    endfunction

    function automatic rvCorePkg::instrU fetchWord(input logic [rvCorePkg::xlen-1:0] addr);
        logic [31:0] index;
        index = (addr - resetPc) >> 2;
        if (index < progLen) return patterns[index + 1];
        return rvCorePkg::nopWord;  // Past the end of the program
    endfunction

    task automatic checkAddr(input string name,
                             input logic [rvCorePkg::xlen-1:0] expected,
                             input logic [rvCorePkg::xlen-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s store address expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkData(input string name,
                             input logic [rvCorePkg::xlen-1:0] expected,
                             input logic [rvCorePkg::xlen-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s store data expected %h actual %h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic checkStore(input logic [rvCorePkg::xlen-1:0] addr,
                              input logic [rvCorePkg::xlen-1:0] wdata);
        logic [rvCorePkg::xlen-1:0] expAddr;
        logic [rvCorePkg::xlen-1:0] expData;
        string                      name;
        if (storesSeen >= storeCount) begin
            $display("unexpected store to %h after all %0d expected stores", addr, storeCount);
            abortRun();
        end else begin
            expAddr = patterns[progLen + 2 + 2 * storesSeen];
            expData = patterns[progLen + 3 + 2 * storesSeen];
            name    = testName(expAddr);
            checkAddr(name, expAddr, addr);
            checkData(name, expData, wdata);
            storesSeen++;
        end
    endtask

    // --------------------
    // Clock, reset and instruction port

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rstN      = 1'b0;
        instrData = rvCorePkg::nopWord;  // Held during reset
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        forever begin
            instrData = fetchWord(instrAddr);
            @(negedge clk);
        end
    end

    // Data memory write and store checking
    always @(posedge clk) begin
        if (rstN) begin
            cycleCount++;
            if (dataWe) begin
                dataMem[dataAddr[9:2]] = dataWdata;
                checkStore(dataAddr, dataWdata);
            end
        end
    end

    // --------------------
    // Main sequence

    initial begin
        for (int i = 0; i < dataWords; i++) begin
            dataMem[i] = 32'hd0d0_0000 | 32'(i * 4);  // Fill tied to the address
        end
        $readmemh("verification/cpuTop_patterns.hex", patterns);
        if ($isunknown(patterns[0])) begin
            $display("pattern file could not be read");
            abortRun();
        end else begin
            progLen    = patterns[0];
            storeCount = patterns[progLen + 1];
            cycleLimit = 8 * progLen + 50;
            while (storesSeen < storeCount && cycleCount < cycleLimit
                   && u_cpuTop.u_cpuTopChk.failCount == 0) begin
                @(negedge clk);
            end
            if (storesSeen == storeCount && u_cpuTop.u_cpuTopChk.failCount == 0) begin
                $display("*** PASSED ***");
                $finish;
            end else begin
                if (u_cpuTop.u_cpuTopChk.failCount != 0) begin
                    $display("bound checker reported %0d assertion failures",
                             u_cpuTop.u_cpuTopChk.failCount);
                end else begin
                    $display("timeout after %0d cycles, only %0d of %0d expected stores arrived",
                             cycleCount, storesSeen, storeCount);
                end
                abortRun();
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/cpuTop_patterns.hex ====
// Word 0 is the program length, then the program words, then the store count
// Store records follow as pairs of address and data
00000044
// Setup, R-type ALU, I-type ALU
06400093 FF900113 0F000193 00208233 10402023 402082B3 10502223 0030F333
10602423 0030E3B3 10702623 00314433 10802823 F3808493 14902023 FFF1C513
14A02223 7030E593 14B02423 7F017613 14C02623 00411693 14D02823 00415713
// Shifts, SLT group, branches
14E02A23 40215793 14F02C23 00112833 19002023 001138B3 19102223 FFF0A913
19202423 FFF0B993 19302623 00108463 1E202E23 00208463 1C102023 00209463
1E202E23 00109463 1C102223 00114463 1E202E23 0020C463 1C102423 0020D463
1E202E23 00115463 1C102623 0020E463 1E202E23 00116463 1C102823 00117463
// Load and store, x0 write, JAL and the final loop
1E202E23 0020F463 1C102A23 20802023 20002A83 21502223 00508013 20002423
00800B6F 1E202E23 25602023 0000006F
0000001A
00000100 0000005D 00000104 0000006B 00000108 00000060 0000010C 000000F4
00000110 FFFFFF09 00000140 FFFFFF9C 00000144 FFFFFF0F 00000148 00000767
0000014C 000007F0 00000150 FFFFFF90 00000154 0FFFFFFF 00000158 FFFFFFFE
00000180 00000001 00000184 00000000 00000188 00000000 0000018C 00000001
000001C0 00000064 000001C4 00000064 000001C8 00000064 000001CC 00000064
000001D0 00000064 000001D4 00000064 00000200 FFFFFF09 00000204 FFFFFF09
00000208 00000000 00000240 00000104

// ==== sim.f ====
source/rvCorePkg.sv
source/instrFetch.sv
source/ctrlDecoder.sv
source/regFile.sv
source/alu.sv
source/cpuTop.sv
verification/cpuTop_chk.sv
verification/cpuTopTb.sv
